// ==== oled_pkg.sv ====
package oled_pkg;

   // frame kinds the serializer knows how to send
   typedef enum logic [1:0] {
      FRAME_CMD   = 2'd0,   // 8-bit command, dc low
      FRAME_DAT8  = 2'd1,   // 8-bit data, dc high
      FRAME_DAT16 = 2'd2    // 16-bit data (one rgb565 pixel), dc high
   } frame_kind_t;

   localparam int FRAME_W    = 16;   // shift register / frame word width
   localparam int BITCNT_W   = 5;    // bit counter, holds 0..16
   localparam int FILL_CNT_W = 16;   // fill repeat count width

   // number of bits a frame puts on the wire
   function automatic logic [BITCNT_W-1:0] frame_bits(frame_kind_t kind);
      logic [BITCNT_W-1:0] n;
      case (kind)
         FRAME_DAT16: n = BITCNT_W'(FRAME_W);
         default:     n = BITCNT_W'(FRAME_W / 2);   // byte frames
      endcase
      return n;
   endfunction

   // dc level for a frame, low only for commands
   function automatic logic frame_dc(frame_kind_t kind);
      return (kind != FRAME_CMD);
   endfunction

endpackage

// ==== oled_regs.sv ====
`timescale 1ns/100ps

module oled_regs import oled_pkg::*; #(
   parameter int fill_cnt_w = FILL_CNT_W   // must not exceed 16, taken from wdata[31:16]
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // cpu write port
   input  logic                  wstrb,        // one write per high cycle
   input  logic                  sel_cntl,     // wdata[1] -> rst pin
   input  logic                  sel_cmd,      // wdata[7:0] as command byte
   input  logic                  sel_dat,      // wdata[7:0] as data byte
   input  logic                  sel_dat16,    // wdata[15:0] as data halfword
   input  logic                  sel_fill,     // colour in [15:0], count in [31:16]
   input  logic [31:0]           wdata,
   input  logic                  engine_busy,  // scheduler still working
   // request towards the scheduler
   output logic                  req_valid,
   output frame_kind_t           req_kind,
   output logic [FRAME_W-1:0]    req_data,
   output logic                  fill_start,
   output logic [FRAME_W-1:0]    fill_colour,
   output logic [fill_cnt_w-1:0] fill_count,
   // display reset pin, active low at the panel
   output logic                  rst_pin
);

   logic accept;      // write allowed to reach the engine
   logic frame_sel;   // any single-frame select

   // frame and fill writes are simply lost while the engine is busy
   assign accept    = wstrb & ~engine_busy;
   assign frame_sel = sel_cmd | sel_dat | sel_dat16;

   assign req_valid  = accept & frame_sel;
   assign fill_start = accept & sel_fill;

   // kind follows the select, byte kinds default to data
   always_comb begin
      if (sel_cmd) begin
         req_kind = FRAME_CMD;
      end else if (sel_dat16) begin
         req_kind = FRAME_DAT16;
      end else begin
         req_kind = FRAME_DAT8;
      end
   end

   // byte frames travel in the low half, serializer does the alignment
   always_comb begin
      if (sel_dat16) begin
         req_data = wdata[FRAME_W-1:0];
      end else begin
         req_data = {{(FRAME_W/2){1'b0}}, wdata[FRAME_W/2-1:0]};
      end
   end

   assign fill_colour = wdata[FRAME_W-1:0];
   assign fill_count  = wdata[16 +: fill_cnt_w];   // repeat count, 0 sends nothing

   // rst pin: display held in reset until software or a frame releases it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rst_pin <= 1'b0;
      end else if (wstrb && sel_cntl) begin
         rst_pin <= wdata[1];          // control writes are never dropped
      end else if (req_valid) begin
         rst_pin <= 1'b1;              // sending anything implies out of reset
      end
   end

endmodule

// ==== oled_frame_sched.sv ====
`timescale 1ns/100ps

module oled_frame_sched import oled_pkg::*; #(
   parameter int fill_cnt_w = FILL_CNT_W
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // from the register block
   input  logic                  req_valid,     // single frame request, one cycle
   input  frame_kind_t           req_kind,
   input  logic [FRAME_W-1:0]    req_data,
   input  logic                  fill_start,    // start of a fill burst, one cycle
   input  logic [FRAME_W-1:0]    fill_colour,
   input  logic [fill_cnt_w-1:0] fill_count,
   // serializer handshake
   input  logic                  busy,          // serializer mid-frame
   output logic                  load,          // one-cycle frame start
   output frame_kind_t           load_kind,
   output logic [FRAME_W-1:0]    load_data,
   // back to the register block and the cpu
   output logic                  engine_busy
);

   logic [FRAME_W-1:0]    colour_q;       // fill colour, held for the whole burst
   logic [fill_cnt_w-1:0] fill_left;      // halfwords still to issue
   logic                  fill_pending;
   logic                  fill_go;        // issue next fill halfword this cycle

   assign fill_pending = (fill_left != '0);

   // load doubles as the issued flag: serializer busy only shows up a cycle
   // after it, so no second issue may happen while it is high
   assign fill_go = fill_pending & ~busy & ~load;

   // control: load pulse and burst counter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         load      <= 1'b0;
         fill_left <= '0;
      end else begin
         load <= req_valid | fill_go;   // both never coincide, see engine_busy
         if (fill_start) begin
            fill_left <= fill_count;
         end else if (fill_go) begin
            fill_left <= fill_left - 1'b1;
         end
      end
   end

   // payload registers, only sampled together with load
   always_ff @(posedge clk) begin
      if (fill_start) begin
         colour_q <= fill_colour;
      end
      if (req_valid) begin
         load_kind <= req_kind;        // cpu frame passes straight through
         load_data <= req_data;
      end else if (fill_go) begin
         load_kind <= FRAME_DAT16;     // fill always sends whole pixels
         load_data <= colour_q;
      end
   end

   // busy while a load is in flight, a frame is on the wire, or the
   // burst still has halfwords left
   // req_valid and fill_start are gated on this, so they only arrive idle
   assign engine_busy = load | busy | fill_pending;

endmodule

// ==== oled_spi_serializer.sv ====
`timescale 1ns/100ps

module oled_spi_serializer import oled_pkg::*; #(
   parameter int clk_div_log2 = 2   // sclk = clk / 2**clk_div_log2, valid 1..3
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               load,        // frame start, only taken while idle
   input  frame_kind_t        load_kind,
   input  logic [FRAME_W-1:0] load_data,   // byte frames in the low half
   output logic               busy,        // bits left to send
   output logic               din,         // to the panel, msb first
   output logic               sclk,        // panel samples on the rising edge
   output logic               cs,          // active low
   output logic               dc           // low = command, high = data
);

   logic [clk_div_log2-1:0] div_cnt;    // free running divider
   logic                    tick;       // last clk cycle before sclk falls
   logic                    shift_en;   // move on to the next bit
   logic [FRAME_W-1:0]      shifter;
   logic [BITCNT_W-1:0]     bit_cnt;    // bits still on their way out

   // divider, top bit is the serial clock
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign sclk = div_cnt[clk_div_log2-1];
   assign tick = &div_cnt;   // counter wraps next edge, sclk goes low with it

   assign busy = (bit_cnt != '0);

   // after the select tick every falling edge retires one bit
   assign shift_en = tick & busy & ~cs & ~load;

   // control: cs, dc and the bit counter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cs      <= 1'b1;
         dc      <= 1'b0;
         bit_cnt <= '0;
      end else if (load) begin
         cs      <= 1'b1;                  // already high when idle
         dc      <= frame_dc(load_kind);   // set up well before cs drops
         bit_cnt <= frame_bits(load_kind);
      end else if (tick && busy) begin
         if (cs) begin
            cs <= 1'b0;                    // first tick selects, msb now on din
         end else begin
            bit_cnt <= bit_cnt - 1'b1;
            // last bit was sampled on the rising edge just passed, so cs goes
            // high on this falling edge and no extra rising edge is seen
            if (bit_cnt == BITCNT_W'(1)) begin
               cs <= 1'b1;
            end
         end
      end
   end

   // shift register, payload only
   always_ff @(posedge clk) begin
      if (load) begin
         if (load_kind == FRAME_DAT16) begin
            shifter <= load_data;
         end else begin
            shifter <= {load_data[FRAME_W/2-1:0], {(FRAME_W/2){1'b0}}};   // msb aligned
         end
      end else if (shift_en) begin
         shifter <= {shifter[FRAME_W-2:0], 1'b0};
      end
   end

   // din parks low whenever the panel is deselected, so it only ever moves
   // on a falling sclk edge
   assign din = ~cs & shifter[FRAME_W-1];

endmodule

// ==== oled_spi_top.sv ====
`timescale 1ns/100ps

module oled_spi_top import oled_pkg::*; #(
   parameter int clk_div_log2 = 2,            // divide by 4 by default
   parameter int fill_cnt_w   = FILL_CNT_W
) (
   input  logic        clk,
   input  logic        rst_n,
   // cpu io page side
   input  logic        wstrb,
   input  logic        sel_cntl,
   input  logic        sel_cmd,
   input  logic        sel_dat,
   input  logic        sel_dat16,
   input  logic        sel_fill,
   input  logic [31:0] wdata,
   output logic        wbusy,       // software polls this before writing
   // ssd1351 / ssd1331 4-wire serial pins
   output logic        din,
   output logic        sclk,
   output logic        cs,
   output logic        dc,
   output logic        rst_pin
);

   // regs -> sched
   logic                  req_valid;
   frame_kind_t           req_kind;
   logic [FRAME_W-1:0]    req_data;
   logic                  fill_start;
   logic [FRAME_W-1:0]    fill_colour;
   logic [fill_cnt_w-1:0] fill_count;
   // sched <-> serializer
   logic                  load;
   frame_kind_t           load_kind;
   logic [FRAME_W-1:0]    load_data;
   logic                  busy;
   logic                  engine_busy;   // sched -> regs, also the cpu wait flag

   assign wbusy = engine_busy;

   oled_regs #(
      .fill_cnt_w  (fill_cnt_w)
   ) i_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .wstrb       (wstrb),
      .sel_cntl    (sel_cntl),
      .sel_cmd     (sel_cmd),
      .sel_dat     (sel_dat),
      .sel_dat16   (sel_dat16),
      .sel_fill    (sel_fill),
      .wdata       (wdata),
      .engine_busy (engine_busy),
      .req_valid   (req_valid),
      .req_kind    (req_kind),
      .req_data    (req_data),
      .fill_start  (fill_start),
      .fill_colour (fill_colour),
      .fill_count  (fill_count),
      .rst_pin     (rst_pin)
   );

   oled_frame_sched #(
      .fill_cnt_w  (fill_cnt_w)
   ) i_sched (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req_kind    (req_kind),
      .req_data    (req_data),
      .fill_start  (fill_start),
      .fill_colour (fill_colour),
      .fill_count  (fill_count),
      .busy        (busy),
      .load        (load),
      .load_kind   (load_kind),
      .load_data   (load_data),
      .engine_busy (engine_busy)
   );

   oled_spi_serializer #(
      .clk_div_log2 (clk_div_log2)
   ) i_ser (
      .clk       (clk),
      .rst_n     (rst_n),
      .load      (load),
      .load_kind (load_kind),
      .load_data (load_data),
      .busy      (busy),
      .din       (din),
      .sclk      (sclk),
      .cs        (cs),
      .dc        (dc)
   );

endmodule

// ==== tb_oled_spi_assertions.sv ====
`timescale 1ns/100ps

module tb_oled_spi_assertions (
   input logic clk,
   input logic rst_n,
   input logic busy,
   input logic din,
   input logic sclk,
   input logic cs,
   input logic dc
);

   int unsigned fail_cnt = 0;   // read by the testbench at the end

   // panel is only selected while a frame is in flight
   cs_low_busy: assert property (@(posedge clk) disable iff (!rst_n)
      !cs |-> (busy || $past(busy)))
   else begin
      fail_cnt++;
      $error("cs low while the serializer has no frame");
   end

   // the panel samples on the rising edge, din holds across it and through the high phase
   din_hold_sclk_high: assert property (@(posedge clk) disable iff (!rst_n)
      sclk |-> $stable(din))
   else begin
      fail_cnt++;
      $error("din moved while sclk was high");
   end

   dc_hold_cs_low: assert property (@(posedge clk) disable iff (!rst_n)
      (!cs && !$past(cs)) |-> $stable(dc))   // command/data flag fixed per frame
   else begin
      fail_cnt++;
      $error("dc moved while cs was low");
   end

endmodule

bind oled_spi_serializer tb_oled_spi_assertions i_assert (
   .clk   (clk),
   .rst_n (rst_n),
   .busy  (busy),
   .din   (din),
   .sclk  (sclk),
   .cs    (cs),
   .dc    (dc)
);

// ==== tb_oled_spi.sv ====
`timescale 1ns/100ps

module tb_oled_spi import oled_pkg::*; ();

   localparam int clk_half_ns = 10;        // 20 ns clock
   localparam int div_log2    = 2;         // sclk = clk / 4
   localparam int max_frames  = 26;        // 6 bytes, 3 halfwords, 2 single frames, fill up to 15
   localparam int watchdog_ns = max_frames * 16 * 4 * 20 + 40000;
   localparam int idle_limit  = 2000;      // cycles allowed for wbusy or cs to settle
   localparam logic [31:0] seed = 32'h1dc219c1;

   // one-hot selects, bit order cntl cmd dat dat16 fill
   localparam logic [4:0] pick_cntl  = 5'b00001;
   localparam logic [4:0] pick_cmd   = 5'b00010;
   localparam logic [4:0] pick_dat   = 5'b00100;
   localparam logic [4:0] pick_dat16 = 5'b01000;
   localparam logic [4:0] pick_fill  = 5'b10000;

   logic        clk;
   logic        rst_n;
   logic        wstrb;
   logic        sel_cntl;
   logic        sel_cmd;
   logic        sel_dat;
   logic        sel_dat16;
   logic        sel_fill;
   logic [31:0] wdata;
   logic        wbusy;
   logic        din;
   logic        sclk;
   logic        cs;
   logic        dc;
   logic        rst_pin;

   int unsigned mismatch_cnt = 0;
   int unsigned other_cnt    = 0;

   // capture monitor state
   logic        cap_q[$];    // every bit the panel samples
   int unsigned len_q[$];    // bits per finished frame
   logic        dc_q[$];     // dc seen during each frame
   int unsigned bits_now;
   logic        dc_now;
   logic        sclk_q = 1'b0;
   logic        cs_q   = 1'b1;

   oled_spi_top #(
      .clk_div_log2 (div_log2)
   ) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .wstrb     (wstrb),
      .sel_cntl  (sel_cntl),
      .sel_cmd   (sel_cmd),
      .sel_dat   (sel_dat),
      .sel_dat16 (sel_dat16),
      .sel_fill  (sel_fill),
      .wdata     (wdata),
      .wbusy     (wbusy),
      .din       (din),
      .sclk      (sclk),
      .cs        (cs),
      .dc        (dc),
      .rst_pin   (rst_pin)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_half_ns) clk = ~clk;
   end

   // display side, an sclk rise shows up as 0 -> 1 between two clk samples
   always @(posedge clk) begin
      if (!rst_n) begin
         sclk_q   = 1'b0;
         cs_q     = 1'b1;
         bits_now = 0;
      end else begin
         if (sclk && !sclk_q && !cs) begin
            cap_q.push_back(din);    // bit taken by the panel on this rise
            bits_now++;
         end
         if (!cs) begin
            dc_now = dc;
         end
         if (cs && !cs_q) begin      // cs released, frame closed
            len_q.push_back(bits_now);
            dc_q.push_back(dc_now);
            bits_now = 0;
         end
         sclk_q = sclk;
         cs_q   = cs;
      end
   end

   initial begin
      #(watchdog_ns);
      $display("watchdog expired after %0d ns, the run did not complete", watchdog_ns);
      $display(">>> FAIL");
      $finish;
   end

   task automatic check_val(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else begin
         $display("MISMATCH %s %s expected %0h actual %0h", name, what, exp, act);
         mismatch_cnt++;
      end
   endtask

   task automatic write_reg(input logic [4:0] sel, input logic [31:0] data);
      @(posedge clk);
      wstrb     <= 1'b1;
      sel_cntl  <= sel[0];
      sel_cmd   <= sel[1];
      sel_dat   <= sel[2];
      sel_dat16 <= sel[3];
      sel_fill  <= sel[4];
      wdata     <= data;
      @(posedge clk);
      wstrb     <= 1'b0;
      sel_cntl  <= 1'b0;
      sel_cmd   <= 1'b0;
      sel_dat   <= 1'b0;
      sel_dat16 <= 1'b0;
      sel_fill  <= 1'b0;
   endtask

   task automatic clear_capture();
      cap_q.delete();
      len_q.delete();
      dc_q.delete();
   endtask

   // wbusy first, then cs, then a few cycles so the monitor closes the frame
   task automatic wait_done(input string name, input logic busy_exp);
      int unsigned n;
      @(posedge clk);
      check_val(name, "wbusy after write", busy_exp, wbusy);
      n = 0;
      while (wbusy === 1'b1 && n < idle_limit) begin
         @(posedge clk);
         n++;
      end
      if (wbusy !== 1'b0) begin
         $display("ERROR %s wbusy did not fall within %0d cycles", name, idle_limit);
         other_cnt++;
      end
      n = 0;
      while (cs !== 1'b1 && n < idle_limit) begin
         @(posedge clk);
         n++;
      end
      if (cs !== 1'b1) begin
         $display("ERROR %s cs did not return high within %0d cycles", name, idle_limit);
         other_cnt++;
      end
      repeat (3) @(posedge clk);
   endtask

   task automatic expect_frames(input string name, input int unsigned n_exp,
                                input int unsigned bits_exp, input logic dc_exp,
                                input logic [15:0] val_exp);
      int unsigned i;
      int unsigned b;
      logic [15:0] val;
      check_val(name, "frame count", n_exp, len_q.size());
      for (i = 0; i < len_q.size(); i++) begin
         check_val(name, "bits in frame", bits_exp, len_q[i]);
         check_val(name, "dc", dc_exp, dc_q[i]);
         val = '0;
         for (b = 0; b < len_q[i]; b++) begin
            val = {val[14:0], cap_q.pop_front()};   // msb arrives first
         end
         check_val(name, "frame value", val_exp, val);
      end
      check_val(name, "bits left over", 0, cap_q.size());
   endtask

   // one cpu frame write, expected bits and dc worked out from the kind
   task automatic send_frame(input string name, input frame_kind_t kind,
                             input logic [31:0] data);
      logic [4:0]  sel;
      int unsigned n_bits;
      logic        dc_exp;
      logic [15:0] exp;
      if (kind == FRAME_CMD) begin
         sel    = pick_cmd;
         n_bits = 8;
         dc_exp = 1'b0;
         exp    = {8'h00, data[7:0]};
      end else if (kind == FRAME_DAT8) begin
         sel    = pick_dat;
         n_bits = 8;
         dc_exp = 1'b1;
         exp    = {8'h00, data[7:0]};
      end else begin
         sel    = pick_dat16;
         n_bits = 16;
         dc_exp = 1'b1;
         exp    = data[15:0];
      end
      clear_capture();
      write_reg(sel, data);
      wait_done(name, 1'b1);
      expect_frames(name, 1, n_bits, dc_exp, exp);
      check_val(name, "rst_pin", 1, rst_pin);   // any frame releases the panel
   endtask

   task automatic test_reset_state();
      int unsigned n;
      @(posedge clk);
      check_val("reset", "cs", 1, cs);
      check_val("reset", "rst_pin", 0, rst_pin);
      check_val("reset", "wbusy", 0, wbusy);
      check_val("reset", "din", 0, din);
      check_val("reset", "dc", 0, dc);
      for (n = 0; n < 20; n++) begin
         @(posedge clk);
         if (cs !== 1'b1) begin
            $display("ERROR reset cs dropped with no write pending");
            other_cnt++;
         end
      end
      expect_frames("reset", 0, 0, 1'b0, 16'h0);   // sclk runs but nothing is taken
   endtask

   task automatic test_bytes();
      int unsigned i;
      for (i = 0; i < 6; i++) begin
         if (i % 2 == 0) begin
            send_frame($sformatf("command byte %0d", i), FRAME_CMD, $urandom);
         end else begin
            send_frame($sformatf("data byte %0d", i), FRAME_DAT8, $urandom);
         end
      end
   endtask

   task automatic test_halfwords();
      int unsigned i;
      for (i = 0; i < 3; i++) begin
         send_frame($sformatf("data halfword %0d", i), FRAME_DAT16, $urandom);
      end
   endtask

   task automatic test_control();
      logic [31:0] data;
      data = $urandom & ~32'h2;   // rst bit low, the rest is noise
      clear_capture();
      write_reg(pick_cntl, data);
      wait_done("control", 1'b0);
      check_val("control", "rst_pin", 0, rst_pin);
      expect_frames("control", 0, 0, 1'b0, 16'h0);
      send_frame("control release", FRAME_CMD, $urandom);
   endtask

   task automatic test_busy_drop();
      logic [31:0] first;
      logic [31:0] second;
      int unsigned n;
      first  = $urandom;
      second = first ^ 32'h0000_00ff;   // differs in every sent bit
      clear_capture();
      write_reg(pick_dat, first);
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (wbusy !== 1'b1 && n < idle_limit);
      check_val("busy drop", "wbusy before second write", 1, wbusy);
      write_reg(pick_dat, second);
      wait_done("busy drop", 1'b1);
      expect_frames("busy drop", 1, 8, 1'b1, {8'h00, first[7:0]});
   endtask

   task automatic test_fill();
      int unsigned r;
      int unsigned count;
      logic [15:0] colour;
      for (r = 0; r < 4; r++) begin
         colour = 16'($urandom);
         count  = (r == 3) ? 0 : 1 + ($urandom % 5);   // last round sends nothing
         clear_capture();
         write_reg(pick_fill, {16'(count), colour});
         wait_done($sformatf("fill %0d", count), count != 0);
         expect_frames($sformatf("fill %0d", count), count, 16, 1'b1, colour);
      end
   endtask

   initial begin
      int unsigned asrt_cnt;
      void'($urandom(seed));
      rst_n     = 1'b0;
      wstrb     = 1'b0;
      sel_cntl  = 1'b0;
      sel_cmd   = 1'b0;
      sel_dat   = 1'b0;
      sel_dat16 = 1'b0;
      sel_fill  = 1'b0;
      wdata     = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      test_reset_state();
      test_bytes();
      test_halfwords();
      test_control();
      test_busy_drop();
      test_fill();
      repeat (4) @(posedge clk);
      asrt_cnt = i_dut.i_ser.i_assert.fail_cnt;
      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatch_cnt, other_cnt, asrt_cnt);
      if (mismatch_cnt + other_cnt + asrt_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
oled_pkg.sv
oled_regs.sv
oled_frame_sched.sv
oled_spi_serializer.sv
oled_spi_top.sv
tb_oled_spi_assertions.sv
tb_oled_spi.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the oled spi testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_oled_spi -f verilog.f -o sim_oled_spi

./obj_dir/sim_oled_spi +verilator+error+limit+1000 | tee sim.log

if grep -qx '>>> PASS' sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi
